/* src/convPkg.sv */
`default_nettype none

package convPkg;

    // data widths
    localparam int PIXEL_W = 8;
    localparam int ADDR_W  = 10;
    // 4 x 255 needs 10 bits, plus sign and one spare
    localparam int RESP_W  = 12;

    typedef logic [PIXEL_W-1:0]       pixel_t;
    typedef logic [ADDR_W-1:0]        addr_t;
    typedef logic signed [RESP_W-1:0] response_t;

    // memory read data heading to the filters
    typedef struct packed {
        pixel_t data;
        logic   valid;
    } sample_t;

    // both filter outputs for one position
    typedef struct packed {
        response_t smooth;
        response_t edgeResp;
        logic      valid;
    } responsePair_t;

    typedef struct packed {
        logic   en;
        addr_t  addr;
        pixel_t data;
    } memWrite_t;

    typedef enum logic [1:0] {
        IDLE,
        LOAD,
        PROCESS,
        READOUT
    } seqState_t;

endpackage

`default_nettype wire

/* src/pixelMemory.sv */
`default_nettype none

module pixelMemory #(
    parameter int IMAGE_DEPTH = 1024
) (
    input  wire logic               i_CLK,
    input  wire logic               i_reset,
    input  wire convPkg::memWrite_t i_write,
    input  wire convPkg::addr_t     i_readAddr,
    input  wire logic               i_readEn,
    output convPkg::sample_t        o_sample
);
    import convPkg::*;

    pixel_t mem [IMAGE_DEPTH];
    pixel_t readData;
    logic   readValid;

    always_ff @(posedge i_CLK) begin
        if (i_write.en) begin
            mem[i_write.addr] <= i_write.data;
        end
    end

    // read data holds between reads, readout depends on that
    always_ff @(posedge i_CLK) begin
        if (i_readEn) begin
            readData <= mem[i_readAddr];
        end
    end

    always_ff @(posedge i_CLK) begin
        if (i_reset) begin
            readValid <= 1'b0;
        end else begin
            readValid <= i_readEn;
        end
    end

    assign o_sample = '{data: readData, valid: readValid};

endmodule

`default_nettype wire

/* src/tapFilter.sv */
`default_nettype none

module tapFilter #(
    parameter int C0 = 1,
    parameter int C1 = 2,
    parameter int C2 = 1
) (
    input  wire logic             i_CLK,
    input  wire logic             i_reset,
    input  wire convPkg::sample_t i_sample,
    output convPkg::response_t    o_response,
    output logic                  o_responseValid
);
    import convPkg::*;

    // x(n-1) and x(n-2)
    pixel_t     prev1;
    pixel_t     prev2;
    // samples seen in the current run, saturates at 2
    logic [1:0] sampleCount;
    int         weightedSum;

    always_comb begin
        weightedSum = C0 * int'(i_sample.data)
                    + C1 * int'(prev1)
                    + C2 * int'(prev2);
    end

    // history and response
    always_ff @(posedge i_CLK) begin
        if (i_sample.valid) begin
            prev1      <= i_sample.data;
            prev2      <= prev1;
            o_response <= response_t'(weightedSum);
        end
    end

    always_ff @(posedge i_CLK) begin
        if (i_reset) begin
            sampleCount     <= 2'd0;
            o_responseValid <= 1'b0;
        end else if (i_sample.valid) begin
            // full window only once two earlier samples exist
            o_responseValid <= (sampleCount == 2'd2);
            if (sampleCount != 2'd2) begin
                sampleCount <= sampleCount + 2'd1;
            end
        end else begin
            // a gap ends the run
            sampleCount     <= 2'd0;
            o_responseValid <= 1'b0;
        end
    end

endmodule

`default_nettype wire

/* src/responseCombiner.sv */
`default_nettype none

module responseCombiner (
    input  wire logic                   i_CLK,
    input  wire logic                   i_reset,
    input  wire convPkg::responsePair_t i_pair,
    output convPkg::pixel_t             o_pixel,
    output logic                        o_pixelValid
);
    import convPkg::*;

    localparam int PIXEL_MAX = (1 << PIXEL_W) - 1;

    logic [RESP_W-1:0] smoothMag;
    logic [RESP_W-1:0] edgeMag;
    logic [RESP_W:0]   total;

    function automatic logic [RESP_W-1:0] magnitude(input response_t value);
        if (value[RESP_W-1]) begin
            return ~value + 1'b1;
        end
        return value;
    endfunction

    always_comb begin
        smoothMag = magnitude(i_pair.smooth);
        edgeMag   = magnitude(i_pair.edgeResp);
        // quarter of smoothing brings the 1,2,1 gain back to unity
        total     = {1'b0, smoothMag >> 2} + {1'b0, edgeMag};
    end

    always_ff @(posedge i_CLK) begin
        o_pixel <= (total > PIXEL_MAX) ? pixel_t'(PIXEL_MAX) : total[PIXEL_W-1:0];
    end

    always_ff @(posedge i_CLK) begin
        if (i_reset) begin
            o_pixelValid <= 1'b0;
        end else begin
            o_pixelValid <= i_pair.valid;
        end
    end

endmodule

`default_nettype wire

/* src/frameSequencer.sv */
`default_nettype none

module frameSequencer #(
    parameter int IMAGE_DEPTH = 1024
) (
    input  wire logic            i_CLK,
    input  wire logic            i_reset,
    input  wire convPkg::pixel_t i_pixel,
    input  wire logic            i_pixelValid,
    output logic                 o_pixelReady,
    input  wire convPkg::addr_t  i_imgLength,
    output convPkg::addr_t       o_readAddr,
    output logic                 o_readEn,
    input  wire convPkg::pixel_t i_memData,
    input  wire convPkg::pixel_t i_combined,
    input  wire logic            i_combinedValid,
    output convPkg::memWrite_t   o_write,
    output convPkg::pixel_t      o_result,
    output logic                 o_resultValid,
    input  wire logic            i_resultReady,
    output logic                 o_endOfFrame
);
    import convPkg::*;

    // longest frame that fits both the memory and the address width
    localparam int MAX_LENGTH = (IMAGE_DEPTH < (1 << ADDR_W)) ? IMAGE_DEPTH
                                                              : (1 << ADDR_W) - 1;
    // three taps need at least three pixels
    localparam int MIN_LENGTH = 3;

    seqState_t state;
    addr_t     imgLength;
    addr_t     clampedLength;
    addr_t     lastPixel;
    addr_t     lastResult;
    addr_t     readCount;
    addr_t     writeCount;
    logic      pixelAccept;
    logic      fetchPending;
    logic      resultValid;

    assign lastPixel  = imgLength - addr_t'(1);
    assign lastResult = imgLength - addr_t'(MIN_LENGTH);

    assign o_pixelReady = (state == IDLE) || (state == LOAD);
    assign pixelAccept  = o_pixelReady && i_pixelValid;

    always_comb begin
        if (int'(i_imgLength) < MIN_LENGTH) begin
            clampedLength = addr_t'(MIN_LENGTH);
        end else if (int'(i_imgLength) > MAX_LENGTH) begin
            clampedLength = addr_t'(MAX_LENGTH);
        end else begin
            clampedLength = i_imgLength;
        end
    end

    // length taken with the first pixel of a frame
    always_ff @(posedge i_CLK) begin
        if (state == IDLE && pixelAccept) begin
            imgLength <= clampedLength;
        end
    end

    always_comb begin
        unique case (state)
            PROCESS: o_readEn = (readCount != imgLength);
            // one fetch per result, only once the previous one is gone
            READOUT: o_readEn = !fetchPending && !resultValid;
            default: o_readEn = 1'b0;
        endcase
    end

    assign o_readAddr = readCount;

    // the same write counter serves load and the lagging result writes
    always_comb begin
        o_write.addr = writeCount;
        o_write.data = (state == PROCESS) ? i_combined : i_pixel;
        unique case (state)
            IDLE, LOAD: o_write.en = pixelAccept;
            PROCESS:    o_write.en = i_combinedValid;
            default:    o_write.en = 1'b0;
        endcase
    end

    always_ff @(posedge i_CLK) begin
        if (i_reset) begin
            state        <= IDLE;
            readCount    <= '0;
            writeCount   <= '0;
            fetchPending <= 1'b0;
            resultValid  <= 1'b0;
        end else begin
            unique case (state)
                IDLE: begin
                    if (pixelAccept) begin
                        writeCount <= addr_t'(1);
                        state      <= LOAD;
                    end
                end
                LOAD: begin
                    if (pixelAccept) begin
                        if (writeCount == lastPixel) begin
                            writeCount <= '0;
                            readCount  <= '0;
                            state      <= PROCESS;
                        end else begin
                            writeCount <= writeCount + addr_t'(1);
                        end
                    end
                end
                PROCESS: begin
                    if (o_readEn) begin
                        readCount <= readCount + addr_t'(1);
                    end
                    if (i_combinedValid) begin
                        if (writeCount == lastResult) begin
                            readCount <= '0;
                            state     <= READOUT;
                        end else begin
                            writeCount <= writeCount + addr_t'(1);
                        end
                    end
                end
                READOUT: begin
                    fetchPending <= o_readEn;
                    if (fetchPending) begin
                        resultValid <= 1'b1;
                    end
                    if (resultValid && i_resultReady) begin
                        resultValid <= 1'b0;
                        if (readCount == lastResult) begin
                            writeCount <= '0;
                            state      <= IDLE;
                        end else begin
                            readCount <= readCount + addr_t'(1);
                        end
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // memory output holds until the next fetch, so the result is stable
    assign o_result      = i_memData;
    assign o_resultValid = resultValid;
    assign o_endOfFrame  = resultValid && (readCount == lastResult);

endmodule

`default_nettype wire

/* src/convSubsystem.sv */
`default_nettype none

module convSubsystem #(
    parameter int IMAGE_DEPTH = 1024,
    // smoothing kernel
    parameter int SMOOTH_C0   = 1,
    parameter int SMOOTH_C1   = 2,
    parameter int SMOOTH_C2   = 1,
    // edge kernel
    parameter int EDGE_C0     = -1,
    parameter int EDGE_C1     = 0,
    parameter int EDGE_C2     = 1
) (
    input  wire logic            i_CLK,
    input  wire logic            i_reset,
    input  wire convPkg::pixel_t i_pixel,
    input  wire logic            i_pixelValid,
    output logic                 o_pixelReady,
    input  wire convPkg::addr_t  i_imgLength,
    output convPkg::pixel_t      o_result,
    output logic                 o_resultValid,
    input  wire logic            i_resultReady,
    output logic                 o_endOfFrame
);
    import convPkg::*;

    memWrite_t     memWrite;
    addr_t         readAddr;
    logic          readEn;
    sample_t       sample;
    responsePair_t pair;
    pixel_t        combined;
    logic          combinedValid;

    pixelMemory #(
        .IMAGE_DEPTH(IMAGE_DEPTH)
    ) u_pixelMemory (
        .i_CLK      (i_CLK),
        .i_reset    (i_reset),
        .i_write    (memWrite),
        .i_readAddr (readAddr),
        .i_readEn   (readEn),
        .o_sample   (sample)
    );

    // both filters share timing, smoothing supplies the pair valid
    tapFilter #(
        .C0(SMOOTH_C0),
        .C1(SMOOTH_C1),
        .C2(SMOOTH_C2)
    ) u_smoothFilter (
        .i_CLK           (i_CLK),
        .i_reset         (i_reset),
        .i_sample        (sample),
        .o_response      (pair.smooth),
        .o_responseValid (pair.valid)
    );

    tapFilter #(
        .C0(EDGE_C0),
        .C1(EDGE_C1),
        .C2(EDGE_C2)
    ) u_edgeFilter (
        .i_CLK           (i_CLK),
        .i_reset         (i_reset),
        .i_sample        (sample),
        .o_response      (pair.edgeResp),
        .o_responseValid ()
    );

    responseCombiner u_combiner (
        .i_CLK        (i_CLK),
        .i_reset      (i_reset),
        .i_pair       (pair),
        .o_pixel      (combined),
        .o_pixelValid (combinedValid)
    );

    frameSequencer #(
        .IMAGE_DEPTH(IMAGE_DEPTH)
    ) u_sequencer (
        .i_CLK           (i_CLK),
        .i_reset         (i_reset),
        .i_pixel         (i_pixel),
        .i_pixelValid    (i_pixelValid),
        .o_pixelReady    (o_pixelReady),
        .i_imgLength     (i_imgLength),
        .o_readAddr      (readAddr),
        .o_readEn        (readEn),
        .i_memData       (sample.data),
        .i_combined      (combined),
        .i_combinedValid (combinedValid),
        .o_write         (memWrite),
        .o_result        (o_result),
        .o_resultValid   (o_resultValid),
        .i_resultReady   (i_resultReady),
        .o_endOfFrame    (o_endOfFrame)
    );

endmodule

`default_nettype wire

/* dv/convSubsystemTb.sv */
`default_nettype none

module convSubsystemTb;
    import convPkg::*;

    localparam int CLK_PERIOD = 8;
    localparam int NUM_TESTS  = 7;
    localparam int MAX_FRAME  = 64;

    typedef enum logic [1:0] {
        RAMP,
        CONSTANT,
        RANDOM,
        STEPS
    } pattern_t;

    // one row of the stimulus table
    typedef struct packed {
        logic [9:0] length;
        pattern_t   pattern;
        logic [7:0] param;
        logic       randomReady;
        logic       busyInput;
        logic [9:0] expCount;
    } testRow_t;

    logic   i_CLK;
    logic   i_reset;
    pixel_t i_pixel;
    logic   i_pixelValid;
    logic   o_pixelReady;
    addr_t  i_imgLength;
    pixel_t o_result;
    logic   o_resultValid;
    logic   i_resultReady;
    logic   o_endOfFrame;

    testRow_t testTable [NUM_TESTS];
    int       framePixels [MAX_FRAME];
    int       expected [MAX_FRAME];
    int       seed;
    int       errorCount;
    int       testErrors;
    int       testsFailed;
    int       received;
    int       saturated;

    convSubsystem dut (
        .i_CLK         (i_CLK),
        .i_reset       (i_reset),
        .i_pixel       (i_pixel),
        .i_pixelValid  (i_pixelValid),
        .o_pixelReady  (o_pixelReady),
        .i_imgLength   (i_imgLength),
        .o_result      (o_result),
        .o_resultValid (o_resultValid),
        .i_resultReady (i_resultReady),
        .o_endOfFrame  (o_endOfFrame)
    );

    always #(CLK_PERIOD / 2) i_CLK = ~i_CLK;

    function automatic testRow_t makeRow(input int length, input pattern_t pattern,
                                         input int param, input logic randomReady,
                                         input logic busyInput, input int expCount);
        testRow_t row;
        row.length      = 10'(length);
        row.pattern     = pattern;
        row.param       = 8'(param);
        row.randomReady = randomReady;
        row.busyInput   = busyInput;
        row.expCount    = 10'(expCount);
        return row;
    endfunction

    // length, pattern, pattern parameter, random ready, busy input, result count
    task automatic fillTable();
        testTable[0] = makeRow(8, RAMP, 16, 1'b0, 1'b0, 6);
        testTable[1] = makeRow(40, RANDOM, 0, 1'b1, 1'b0, 38);
        testTable[2] = makeRow(3, RAMP, 40, 1'b0, 1'b0, 1);
        testTable[3] = makeRow(16, STEPS, 3, 1'b1, 1'b0, 14);
        testTable[4] = makeRow(12, CONSTANT, 200, 1'b0, 1'b0, 10);
        testTable[5] = makeRow(24, RANDOM, 0, 1'b1, 1'b1, 22);
        testTable[6] = makeRow(10, RAMP, 25, 1'b0, 1'b0, 8);
    endtask

    // step width for STEPS is the pattern parameter
    task automatic buildFrame(input testRow_t row);
        for (int i = 0; i < int'(row.length); i++) begin
            case (row.pattern)
                RAMP:     framePixels[i] = (i * int'(row.param)) % 256;
                CONSTANT: framePixels[i] = int'(row.param);
                RANDOM:   framePixels[i] = $random(seed) & 255;
                default:  framePixels[i] = ((i / int'(row.param)) % 2 == 1) ? 255 : 0;
            endcase
        end
    endtask

    // kernels (1,2,1) and (-1,0,1) on x(n), x(n-1), x(n-2), then the combiner rule
    function automatic int modelPixel(input int xn, input int xn1, input int xn2);
        int smooth;
        int edgeVal;
        int sum;
        smooth  = xn + 2 * xn1 + xn2;
        edgeVal = xn2 - xn;
        if (edgeVal < 0) begin
            edgeVal = -edgeVal;
        end
        sum = smooth / 4 + edgeVal;
        return (sum > 255) ? 255 : sum;
    endfunction

    task automatic computeExpected(input testRow_t row);
        for (int k = 0; k < int'(row.expCount); k++) begin
            expected[k] = modelPixel(framePixels[k + 2], framePixels[k + 1], framePixels[k]);
        end
    endtask

    task automatic loadFrame(input testRow_t row);
        logic accepted;
        for (int i = 0; i < int'(row.length); i++) begin
            @(negedge i_CLK);
            i_pixel      = pixel_t'(framePixels[i]);
            i_pixelValid = 1'b1;
            i_imgLength  = row.length;
            accepted     = 1'b0;
            while (!accepted) begin
                accepted = o_pixelReady;
                @(posedge i_CLK);
                if (!accepted) begin
                    @(negedge i_CLK);
                end
            end
        end
    endtask

    task automatic collectResults(input testRow_t row, input int testIdx);
        logic   holding;
        pixel_t heldValue;
        int     readyDraw;
        received  = 0;
        saturated = 0;
        holding   = 1'b0;
        while (received < int'(row.expCount)) begin
            @(negedge i_CLK);
            // busy rows keep offering a dummy pixel
            i_pixelValid  = row.busyInput;
            i_pixel       = row.busyInput ? 8'hA5 : 8'h00;
            readyDraw     = $random(seed);
            i_resultReady = row.randomReady ? readyDraw[0] : 1'b1;
            if (row.busyInput) begin
                assert (!o_pixelReady) else begin
                    $display("test %0d: DUT was ready for input while busy", testIdx);
                    testErrors++;
                end
            end
            if (holding) begin
                assert (o_resultValid) else begin
                    $display("test %0d: result valid dropped before its transfer", testIdx);
                    testErrors++;
                end
                assert (!o_resultValid || o_result == heldValue) else begin
                    $display("ERROR test %0d: o_result = 0x%02h, held 0x%02h",
                             testIdx, o_result, heldValue);
                    testErrors++;
                end
            end
            assert (o_resultValid || !o_endOfFrame) else begin
                $display("test %0d: end of frame raised without a valid result", testIdx);
                testErrors++;
            end
            if (o_resultValid && i_resultReady) begin
                assert (int'(o_result) == expected[received]) else begin
                    $display("ERROR test %0d result %0d: o_result = 0x%02h, expected 0x%02h",
                             testIdx, received, o_result, expected[received]);
                    testErrors++;
                end
                assert (o_endOfFrame == (received == int'(row.expCount) - 1)) else begin
                    $display("ERROR test %0d result %0d: o_endOfFrame = 0x%0h, expected 0x%0h",
                             testIdx, received, o_endOfFrame,
                             (received == int'(row.expCount) - 1));
                    testErrors++;
                end
                if (row.pattern == CONSTANT) begin
                    assert (o_result == row.param) else begin
                        $display("ERROR test %0d: o_result = 0x%02h, expected 0x%02h",
                                 testIdx, o_result, row.param);
                        testErrors++;
                    end
                end
                if (o_result == 8'hFF) begin
                    saturated++;
                end
                received++;
                holding = 1'b0;
            end else if (o_resultValid) begin
                holding   = 1'b1;
                heldValue = o_result;
            end
        end
        // last transfer happens on this edge
        @(posedge i_CLK);
        @(negedge i_CLK);
        i_pixelValid = 1'b0;
        assert (o_pixelReady && !o_resultValid) else begin
            $display("test %0d: DUT did not return to idle after the last result", testIdx);
            testErrors++;
        end
    endtask

    function automatic int cycleBudget();
        int total;
        total = 0;
        for (int t = 0; t < NUM_TESTS; t++) begin
            total += 20 * int'(testTable[t].length);
        end
        return total + 200;
    endfunction

    initial begin
        @(negedge i_reset);
        #(cycleBudget() * CLK_PERIOD);
        $display("watchdog: run did not finish within %0d cycles", cycleBudget());
        $display("Result: FAILED");
        $finish;
    end

    initial begin
        i_CLK         = 1'b0;
        i_reset       = 1'b1;
        i_pixel       = '0;
        i_pixelValid  = 1'b0;
        i_imgLength   = '0;
        i_resultReady = 1'b0;
        seed          = 37;
        errorCount    = 0;
        testsFailed   = 0;
        fillTable();
        repeat (2) @(posedge i_CLK);
        @(negedge i_CLK);
        i_reset    = 1'b0;
        testErrors = 0;
        assert (!o_resultValid && !o_endOfFrame) else begin
            $display("ERROR reset: o_resultValid = 0x%0h, o_endOfFrame = 0x%0h, expected 0x0",
                     o_resultValid, o_endOfFrame);
            testErrors++;
        end
        assert (o_pixelReady) else begin
            $display("ERROR reset: o_pixelReady = 0x%0h, expected 0x1", o_pixelReady);
            testErrors++;
        end
        $display("test 0: reset state, %0s", (testErrors == 0) ? "ok" : "failed");
        errorCount += testErrors;
        testsFailed += (testErrors != 0) ? 1 : 0;
        for (int t = 0; t < NUM_TESTS; t++) begin
            testErrors = 0;
            buildFrame(testTable[t]);
            computeExpected(testTable[t]);
            loadFrame(testTable[t]);
            collectResults(testTable[t], t + 1);
            $display("test %0d: length %0d, %0d of %0d results, %0d at 0xFF, %0s",
                     t + 1, testTable[t].length, received, testTable[t].expCount,
                     saturated, (testErrors == 0) ? "ok" : "failed");
            errorCount += testErrors;
            testsFailed += (testErrors != 0) ? 1 : 0;
        end
        $display("tests run: %0d, tests failed: %0d, errors: %0d",
                 NUM_TESTS + 1, testsFailed, errorCount);
        if (errorCount == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* sim.f */
src/convPkg.sv
src/pixelMemory.sv
src/tapFilter.sv
src/responseCombiner.sv
src/frameSequencer.sv
src/convSubsystem.sv
dv/convSubsystemTb.sv

/* run.sh */
#!/bin/sh
# build and run the convolution testbench with Verilator

cd "$(dirname "$0")" || exit 1

TOP=convSubsystemTb
BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --assert -Wno-fatal -f sim.f \
    --top-module "$TOP" --Mdir "$BUILD_DIR" -o "$TOP"
status=$?
if [ "$status" -ne 0 ]; then
    echo "compile failed with status $status"
    exit 1
fi

"./$BUILD_DIR/$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^Result: PASSED$" "$LOG"; then
    echo "simulation passed"
    exit 0
else
    echo "simulation failed, see $LOG"
    exit 1
fi
